// ==== opl3_voice.f ====
verilog/opl3_pkg.sv
verilog/axi_lite_pkg.sv
verilog/voice_regs.sv
verilog/sample_clk_div.sv
verilog/phase_gen.sv
verilog/operator_wave.sv
verilog/i2s_tx.sv
verilog/opl3_voice.sv
tests/opl3_voice_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the FM voice testbench with Verilator and runs it.
# Exit status is non-zero when the simulation reports a failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module opl3_voice_tb \
    -f opl3_voice.f \
    -o opl3_voice_sim

./obj_dir/opl3_voice_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
grep -q "Verification passed" sim.log

// ==== tests/opl3_voice_tb.sv ====
// Testbench for the FM voice
// Drives the voice registers over AXI4-Lite, rebuilds every I2S frame and
// compares it with a reference model of the waveform, attenuation and gating
// Run it with run_sim.sh from the project root

`timescale 1ns/1ps

module opl3_voice_tb import opl3_pkg::*, axi_lite_pkg::*; ();

    localparam int SAMPLE_DIV = 80;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam int WAVE_FRAMES = 16;
    localparam int VOICE_TESTS = 8;
    localparam int FRAMES_PER_TEST = 24;
    localparam int MARGIN_NS = 40000;
    localparam int WATCHDOG_NS =
        VOICE_TESTS * FRAMES_PER_TEST * SAMPLE_DIV * CLK_PERIOD + MARGIN_NS;
    localparam logic [31:0] RANDOM_SEED = 32'hde8f;
    // Field bits of each register, everything else is padding
    localparam logic [31:0] FREQ_MASK = 32'h0003_ffff;
    localparam logic [31:0] OP_MASK = 32'h0000_00ff;
    localparam logic [7:0] ADDR_BAD_WR = 8'h08;
    localparam logic [7:0] ADDR_BAD_RD = 8'h0c;
    // Each setting moves the phase through both halves of the wave within WAVE_FRAMES
    localparam int FNUM_TABLE [4] = '{700, 1000, 345, 513};
    localparam int BLOCK_TABLE [4] = '{6, 7, 7, 4};
    localparam int MULT_TABLE [4] = '{1, 0, 3, 15};

    logic clk;
    logic rst;
    axi_lite_req_t axi_req;
    axi_lite_rsp_t axi_rsp;
    logic i2s_sclk;
    logic i2s_ws;
    logic i2s_sd;
    int frame_count = 0;
    logic [31:0] expect_q[$];

    opl3_voice #(
        .SAMPLE_DIV(SAMPLE_DIV)
    ) opl3_voice_inst (
        .clk(clk),
        .rst(rst),
        .axi_req(axi_req),
        .axi_rsp(axi_rsp),
        .i2s_sclk(i2s_sclk),
        .i2s_ws(i2s_ws),
        .i2s_sd(i2s_sd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s actual 0x%08h expected 0x%08h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // ##################################################
    // Reference model
    // ##################################################
    function automatic logic [19:0] phase_increment(input freq_reg_t freq);
        int shifted;
        int mult2;
        shifted = int'(freq.fnum) << freq.block;
        // mult 0 stands for one half
        mult2 = (freq.mult == 4'd0) ? 1 : 2 * int'(freq.mult);
        return 20'((shifted * mult2) >> 1);
    endfunction

    // Returns the expected frame as {left, right}
    function automatic logic [31:0] expected_sample(input logic [19:0] phase, input op_reg_t op);
        int p;
        int w;
        logic signed [15:0] s;
        p = int'(phase[19:10]);
        case (op.wave_sel)
            WAVE_TRIANGLE: w = (p < 512) ? (p - 256) * 128 : (767 - p) * 128;
            WAVE_HALF_TRIANGLE: w = (p < 512) ? (p - 256) * 128 : 0;
            WAVE_SQUARE: w = (p < 512) ? 32704 : -32704;
            default: w = (p - 512) * 64;
        endcase
        w = w >>> op.atten;
        s = 16'(w);
        return {op.cha ? s : 16'h0, op.chb ? s : 16'h0};
    endfunction

    // ##################################################
    // AXI4-Lite host
    // ##################################################
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int delay;
        @(posedge clk);
        axi_req.awvalid <= 1'b1;
        axi_req.awaddr <= addr;
        axi_req.wvalid <= 1'b1;
        axi_req.wdata <= data;
        axi_req.wstrb <= strb;
        do begin
            @(negedge clk);
        end while (!axi_rsp.awready);
        // Address and data are taken in the same cycle
        check_value("wready", 32'(axi_rsp.wready), 32'h1);
        @(posedge clk);
        axi_req.awvalid <= 1'b0;
        axi_req.wvalid <= 1'b0;
        delay = $urandom_range(2, 0);
        repeat (delay) @(posedge clk);
        axi_req.bready <= 1'b1;
        do begin
            @(negedge clk);
        end while (!axi_rsp.bvalid);
        resp = axi_rsp.bresp;
        @(posedge clk);
        axi_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int delay;
        @(posedge clk);
        axi_req.arvalid <= 1'b1;
        axi_req.araddr <= addr;
        do begin
            @(negedge clk);
        end while (!axi_rsp.arready);
        @(posedge clk);
        axi_req.arvalid <= 1'b0;
        delay = $urandom_range(2, 0);
        repeat (delay) @(posedge clk);
        axi_req.rready <= 1'b1;
        do begin
            @(negedge clk);
        end while (!axi_rsp.rvalid);
        data = axi_rsp.rdata;
        resp = axi_rsp.rresp;
        @(posedge clk);
        axi_req.rready <= 1'b0;
    endtask

    task automatic wait_frames(input int count);
        int target;
        target = frame_count + count;
        while (frame_count < target) @(posedge clk);
    endtask

    task automatic wait_expected_empty();
        while (expect_q.size() != 0) @(posedge clk);
    endtask

    // Key-off frames first, then WAVE_FRAMES frames after key-on
    task automatic run_voice_test(input freq_reg_t freq, input op_reg_t op);
        logic [1:0] resp;
        logic [19:0] inc;
        logic [19:0] phase;
        reg_word_u word;
        int k;
        @(negedge i2s_ws);
        word.op = op;
        axi_write(ADDR_OP, word, 4'hf, resp);
        check_value("bresp", 32'(resp), 32'(RESP_OKAY));
        freq.key_on = 1'b0;
        word.freq = freq;
        axi_write(ADDR_FREQ, word, 4'hf, resp);
        check_value("bresp", 32'(resp), 32'(RESP_OKAY));
        // The next frame still carries the old operator setting
        wait_frames(1);
        repeat (2) expect_q.push_back(expected_sample(20'h0, op));
        wait_expected_empty();
        @(negedge i2s_ws);
        freq.key_on = 1'b1;
        word.freq = freq;
        axi_write(ADDR_FREQ, word, 4'hf, resp);
        check_value("bresp", 32'(resp), 32'(RESP_OKAY));
        inc = phase_increment(freq);
        phase = '0;
        for (k = 0; k < WAVE_FRAMES; k++) begin
            expect_q.push_back(expected_sample(phase, op));
            phase = phase + inc;
        end
        wait_expected_empty();
    endtask

    // ##################################################
    // I2S capture and compare
    // ##################################################
    initial begin : i2s_monitor
        logic [31:0] bits;
        logic [31:0] exp_frame;
        int slot;
        bits = '0;
        slot = 0;
        forever begin
            @(posedge i2s_sclk);
            // ws goes high one bit before the right MSB and falls one bit before the end
            check_value("i2s_ws", 32'(i2s_ws), 32'(slot >= 15 && slot < 31));
            bits = {bits[30:0], i2s_sd};
            slot++;
            if (slot == 32) begin
                slot = 0;
                frame_count++;
                if (expect_q.size() > 0) begin
                    exp_frame = expect_q.pop_front();
                    check_value("left", {16'h0, bits[31:16]}, {16'h0, exp_frame[31:16]});
                    check_value("right", {16'h0, bits[15:0]}, {16'h0, exp_frame[15:0]});
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] data;
        logic [31:0] rdata;
        logic [31:0] mask;
        logic [31:0] freq_val;
        logic [31:0] op_val;
        logic [7:0] addr;
        logic [1:0] resp;
        freq_reg_t freq;
        op_reg_t op;
        int i;
        void'($urandom(RANDOM_SEED));
        rst = 1'b1;
        axi_req = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("axi ready/valid", 32'({axi_rsp.awready, axi_rsp.wready, axi_rsp.bvalid,
                                            axi_rsp.arready, axi_rsp.rvalid}), 32'h0);
        check_value("i2s outputs", 32'({i2s_sclk, i2s_ws, i2s_sd}), 32'h0);

        // Registers come out of reset as zero, then random readback
        for (i = 0; i < 10; i++) begin
            addr = (i % 2 == 0) ? ADDR_FREQ : ADDR_OP;
            mask = (i % 2 == 0) ? FREQ_MASK : OP_MASK;
            data = (i < 2) ? 32'h0 : $urandom();
            if (i >= 2) begin
                axi_write(addr, data, 4'hf, resp);
                check_value("bresp", 32'(resp), 32'(RESP_OKAY));
            end
            axi_read(addr, rdata, resp);
            check_value("rresp", 32'(resp), 32'(RESP_OKAY));
            check_value("rdata", rdata, data & mask);
        end

        // Unknown addresses and partial strobes leave the registers alone
        axi_read(ADDR_FREQ, freq_val, resp);
        axi_read(ADDR_OP, op_val, resp);
        axi_write(ADDR_BAD_WR, $urandom(), 4'hf, resp);
        check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
        axi_write(ADDR_FREQ, ~freq_val, 4'b0111, resp);
        axi_read(ADDR_BAD_RD, rdata, resp);
        check_value("rresp", 32'(resp), 32'(RESP_SLVERR));
        check_value("rdata", rdata, 32'h0);
        axi_read(ADDR_FREQ, rdata, resp);
        check_value("freq register", rdata, freq_val);
        axi_read(ADDR_OP, rdata, resp);
        check_value("op register", rdata, op_val);

        // One pass per waveform, full level on both channels
        for (i = 0; i < 4; i++) begin
            freq = '0;
            op = '0;
            freq.fnum = 10'(FNUM_TABLE[i]);
            freq.block = 3'(BLOCK_TABLE[i]);
            freq.mult = 4'(MULT_TABLE[i]);
            op.wave_sel = wave_sel_e'(2'(i));
            op.cha = 1'b1;
            op.chb = 1'b1;
            run_voice_test(freq, op);
        end

        // Random settings, walking through all channel enable combinations
        for (i = 0; i < VOICE_TESTS - 4; i++) begin
            freq = '0;
            op = '0;
            freq.fnum = 10'($urandom());
            freq.block = 3'($urandom());
            freq.mult = 4'($urandom());
            op.wave_sel = wave_sel_e'(2'($urandom()));
            op.atten = 4'($urandom());
            op.cha = i[0];
            op.chb = i[1];
            run_voice_test(freq, op);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verilog/axi_lite_pkg.sv ====
// AXI4-Lite channel bundles, response codes and the voice register map
// Used by the register block and by whatever drives the host side

package axi_lite_pkg;

    localparam int AXI_ADDR_WIDTH = 8;
    localparam int AXI_DATA_WIDTH = 32;

    typedef struct packed {
        logic awvalid;
        logic [AXI_ADDR_WIDTH-1:0] awaddr;
        logic wvalid;
        logic [AXI_DATA_WIDTH-1:0] wdata;
        logic [AXI_DATA_WIDTH/8-1:0] wstrb;
        logic bready;
        logic arvalid;
        logic [AXI_ADDR_WIDTH-1:0] araddr;
        logic rready;
    } axi_lite_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
        logic arready;
        logic rvalid;
        logic [AXI_DATA_WIDTH-1:0] rdata;
        logic [1:0] rresp;
    } axi_lite_rsp_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_FREQ = 8'h00;
    localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_OP = 8'h04;

endpackage

// ==== verilog/i2s_tx.sv ====
// I2S transmitter for one stereo frame per audio sample
// A frame is 64 clocks with sclk at half the clock rate; ws leads the data
// by one bit and the line idles low between frames

`timescale 1ns/1ps

module i2s_tx import opl3_pkg::*; (
    input logic clk,
    input logic rst,
    input logic sample_en,
    input logic signed [SAMPLE_WIDTH-1:0] left,
    input logic signed [SAMPLE_WIDTH-1:0] right,
    output logic i2s_sclk,
    output logic i2s_ws,
    output logic i2s_sd
);

    localparam int FRAME_CLKS = 4 * SAMPLE_WIDTH;
    localparam int CNT_WIDTH = $clog2(FRAME_CLKS);
    localparam int SLOT_WIDTH = CNT_WIDTH - 1;

    logic active;
    logic [CNT_WIDTH-1:0] cnt;
    logic [CNT_WIDTH-1:0] cnt_next;
    logic [SLOT_WIDTH-1:0] slot_next;
    logic [2*SAMPLE_WIDTH-1:0] shreg;

    assign cnt_next = cnt + 1'b1;
    assign slot_next = cnt_next[CNT_WIDTH-1:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cnt <= '0;
            i2s_sclk <= 1'b0;
            i2s_ws <= 1'b0;
            i2s_sd <= 1'b0;
        end else if (sample_en) begin
            // Left MSB goes out in the first bit slot, ws is already low
            active <= 1'b1;
            cnt <= '0;
            i2s_sclk <= 1'b0;
            i2s_sd <= left[SAMPLE_WIDTH-1];
        end else if (active) begin
            if (cnt == CNT_WIDTH'(FRAME_CLKS - 1)) begin
                active <= 1'b0;
                i2s_sclk <= 1'b0;
                i2s_sd <= 1'b0;
            end else begin
                cnt <= cnt_next;
                i2s_sclk <= cnt_next[0];
                // Falling sclk edge starts a new bit slot
                if (!cnt_next[0]) begin
                    i2s_sd <= shreg[2*SAMPLE_WIDTH-1];
                    i2s_ws <= (slot_next >= SLOT_WIDTH'(SAMPLE_WIDTH - 1)) &&
                              (slot_next < SLOT_WIDTH'(2 * SAMPLE_WIDTH - 1));
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_en) begin
            shreg <= {left[SAMPLE_WIDTH-2:0], right, 1'b0};
        end else if (active && !cnt_next[0]) begin
            shreg <= {shreg[2*SAMPLE_WIDTH-2:0], 1'b0};
        end
    end

endmodule

// ==== verilog/operator_wave.sv ====
// Operator output stage
// Turns the phase into one of four waveforms, applies attenuation and gates
// the left and right channels; samples update the cycle after the phase moves

`timescale 1ns/1ps

module operator_wave import opl3_pkg::*; (
    input logic clk,
    input logic rst,
    input logic sample_en,
    input logic [PHASE_WIDTH-1:0] phase,
    input voice_cfg_t cfg,
    output logic signed [SAMPLE_WIDTH-1:0] left,
    output logic signed [SAMPLE_WIDTH-1:0] right
);

    // Only the top phase bits shape the wave
    localparam int P_WIDTH = 10;
    localparam logic signed [P_WIDTH:0] TRI_LOW = 256;
    localparam logic signed [P_WIDTH:0] TRI_HIGH = 767;
    localparam logic signed [SAMPLE_WIDTH-1:0] SQUARE_LEVEL = 32704;

    logic [P_WIDTH-1:0] p;
    logic signed [P_WIDTH:0] tri_lin;
    logic signed [SAMPLE_WIDTH-1:0] tri_wave;
    logic signed [SAMPLE_WIDTH-1:0] saw_wave;
    logic signed [SAMPLE_WIDTH-1:0] wave;
    logic signed [SAMPLE_WIDTH-1:0] scaled;
    logic load_q;

    assign p = phase[PHASE_WIDTH-1 -: P_WIDTH];

    // Rising half then falling half, both within -256..255
    always_comb begin
        if (!p[P_WIDTH-1]) begin
            tri_lin = $signed({1'b0, p}) - TRI_LOW;
        end else begin
            tri_lin = TRI_HIGH - $signed({1'b0, p});
        end
    end

    // Times 128 and times 64 are plain bit placements
    assign tri_wave = {tri_lin[P_WIDTH-2:0], {(SAMPLE_WIDTH - P_WIDTH + 1){1'b0}}};
    assign saw_wave = {~p[P_WIDTH-1], p[P_WIDTH-2:0], {(SAMPLE_WIDTH - P_WIDTH){1'b0}}};

    always_comb begin
        case (cfg.op.wave_sel)
            WAVE_TRIANGLE: wave = tri_wave;
            WAVE_HALF_TRIANGLE: wave = p[P_WIDTH-1] ? '0 : tri_wave;
            WAVE_SQUARE: wave = p[P_WIDTH-1] ? -SQUARE_LEVEL : SQUARE_LEVEL;
            default: wave = saw_wave;
        endcase
    end

    assign scaled = wave >>> cfg.op.atten;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_q <= 1'b0;
            left <= '0;
            right <= '0;
        end else begin
            load_q <= sample_en;
            if (load_q) begin
                left <= cfg.op.cha ? scaled : '0;
                right <= cfg.op.chb ? scaled : '0;
            end
        end
    end

endmodule

// ==== verilog/opl3_pkg.sv ====
// Widths, register layouts and waveform codes for the FM voice
// Import this package wherever voice configuration or audio samples are handled

package opl3_pkg;

    // ##################################################
    // Datapath widths
    // ##################################################
    localparam int SAMPLE_WIDTH = 16;
    localparam int PHASE_WIDTH = 20;
    localparam int FNUM_WIDTH = 10;
    localparam int BLOCK_WIDTH = 3;
    localparam int MULT_WIDTH = 4;
    localparam int ATTEN_WIDTH = 4;
    localparam int REG_WIDTH = 32;

    localparam int FREQ_PAD_WIDTH = REG_WIDTH - 1 - BLOCK_WIDTH - FNUM_WIDTH - MULT_WIDTH;
    localparam int OP_PAD_WIDTH = REG_WIDTH - 2 - ATTEN_WIDTH - 2;

    typedef enum logic [1:0] {
        WAVE_TRIANGLE,
        WAVE_HALF_TRIANGLE,
        WAVE_SQUARE,
        WAVE_SAW
    } wave_sel_e;

    // ##################################################
    // Register words
    // ##################################################
    typedef struct packed {
        logic [FREQ_PAD_WIDTH-1:0] pad;
        logic key_on;
        logic [BLOCK_WIDTH-1:0] block;
        logic [FNUM_WIDTH-1:0] fnum;
        logic [MULT_WIDTH-1:0] mult;
    } freq_reg_t;

    typedef struct packed {
        logic [OP_PAD_WIDTH-1:0] pad;
        wave_sel_e wave_sel;
        logic [ATTEN_WIDTH-1:0] atten;
        logic cha;
        logic chb;
    } op_reg_t;

    // The same bus word seen as either register
    typedef union packed {
        freq_reg_t freq;
        op_reg_t op;
    } reg_word_u;

    typedef struct packed {
        freq_reg_t freq;
        op_reg_t op;
    } voice_cfg_t;

endpackage

// ==== verilog/opl3_voice.sv ====
// Top level of the single FM voice
// Host registers come in over AXI4-Lite, audio leaves as I2S; SAMPLE_DIV
// sets the clocks per sample and must be at least 64

`timescale 1ns/1ps

module opl3_voice import opl3_pkg::*, axi_lite_pkg::*; #(
    parameter int SAMPLE_DIV = 64
) (
    input logic clk,
    input logic rst,
    input axi_lite_req_t axi_req,
    output axi_lite_rsp_t axi_rsp,
    output logic i2s_sclk,
    output logic i2s_ws,
    output logic i2s_sd
);

    voice_cfg_t cfg;
    logic sample_en;
    logic [PHASE_WIDTH-1:0] phase;
    logic signed [SAMPLE_WIDTH-1:0] left;
    logic signed [SAMPLE_WIDTH-1:0] right;

    voice_regs voice_regs_inst (
        .clk(clk),
        .rst(rst),
        .axi_req(axi_req),
        .axi_rsp(axi_rsp),
        .cfg(cfg)
    );

    sample_clk_div #(
        .SAMPLE_DIV(SAMPLE_DIV)
    ) sample_clk_div_inst (
        .clk(clk),
        .rst(rst),
        .sample_en(sample_en)
    );

    phase_gen phase_gen_inst (
        .clk(clk),
        .rst(rst),
        .sample_en(sample_en),
        .cfg(cfg),
        .phase(phase)
    );

    operator_wave operator_wave_inst (
        .clk(clk),
        .rst(rst),
        .sample_en(sample_en),
        .phase(phase),
        .cfg(cfg),
        .left(left),
        .right(right)
    );

    i2s_tx i2s_tx_inst (
        .clk(clk),
        .rst(rst),
        .sample_en(sample_en),
        .left(left),
        .right(right),
        .i2s_sclk(i2s_sclk),
        .i2s_ws(i2s_ws),
        .i2s_sd(i2s_sd)
    );

endmodule

// ==== verilog/phase_gen.sv ====
// Phase accumulator of the voice
// The increment follows fnum, block and mult; the phase advances once per
// sample and sits at zero while the key is off

`timescale 1ns/1ps

module phase_gen import opl3_pkg::*; (
    input logic clk,
    input logic rst,
    input logic sample_en,
    input voice_cfg_t cfg,
    output logic [PHASE_WIDTH-1:0] phase
);

    // fnum shifted by the largest block value
    localparam int SHIFT_WIDTH = FNUM_WIDTH + (1 << BLOCK_WIDTH) - 1;
    localparam int PROD_WIDTH = SHIFT_WIDTH + MULT_WIDTH + 1;

    logic [SHIFT_WIDTH-1:0] fnum_shifted;
    logic [MULT_WIDTH:0] mult_x2;
    logic [PROD_WIDTH-1:0] product;
    logic [PHASE_WIDTH-1:0] phase_inc;

    assign fnum_shifted = SHIFT_WIDTH'(cfg.freq.fnum) << cfg.freq.block;

    // Multiplier is doubled so that mult 0 can stand for one half
    assign mult_x2 = (cfg.freq.mult == '0) ? (MULT_WIDTH + 1)'(1) : {cfg.freq.mult, 1'b0};

    assign product = PROD_WIDTH'(fnum_shifted) * PROD_WIDTH'(mult_x2);

    // Drop the doubling again; upper bits fall off with the phase wrap
    assign phase_inc = product[PHASE_WIDTH:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else if (sample_en) begin
            if (!cfg.freq.key_on) begin
                phase <= '0;
            end else begin
                phase <= phase + phase_inc;
            end
        end
    end

endmodule

// ==== verilog/sample_clk_div.sv ====
// Audio sample rate divider
// Gives a one-cycle sample_en every SAMPLE_DIV clocks, first one SAMPLE_DIV
// clocks after reset is released

`timescale 1ns/1ps

module sample_clk_div #(
    parameter int SAMPLE_DIV = 64
) (
    input logic clk,
    input logic rst,
    output logic sample_en
);

    localparam int CNT_WIDTH = $clog2(SAMPLE_DIV);
    localparam logic [CNT_WIDTH-1:0] LAST_COUNT = CNT_WIDTH'(SAMPLE_DIV - 1);

    logic [CNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || count == LAST_COUNT) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Counter is a flop, so the decode is clean
    assign sample_en = (count == LAST_COUNT);

endmodule

// ==== verilog/voice_regs.sv ====
// AXI4-Lite slave holding the frequency and operator registers of the voice
// Writes need full strobes; unknown addresses answer SLVERR and change nothing

`timescale 1ns/1ps

module voice_regs import opl3_pkg::*, axi_lite_pkg::*; (
    input logic clk,
    input logic rst,
    input axi_lite_req_t axi_req,
    output axi_lite_rsp_t axi_rsp,
    output voice_cfg_t cfg
);

    logic wr_fire;
    logic rd_fire;
    logic bvalid_q;
    logic [1:0] bresp_q;
    logic rvalid_q;
    logic [1:0] rresp_q;
    logic [AXI_DATA_WIDTH-1:0] rdata_q;
    reg_word_u wr_word;
    freq_reg_t freq_wr;
    op_reg_t op_wr;

    // A write needs address and data together and no response pending
    assign wr_fire = axi_req.awvalid && axi_req.wvalid && !bvalid_q;
    assign rd_fire = axi_req.arvalid && !rvalid_q;

    assign wr_word = axi_req.wdata;

    // Padding is dropped on the way in so it always reads back as zero
    always_comb begin
        freq_wr = wr_word.freq;
        freq_wr.pad = '0;
        op_wr = wr_word.op;
        op_wr.pad = '0;
    end

    // ##################################################
    // Write channel
    // ##################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
            bvalid_q <= 1'b0;
            bresp_q <= RESP_OKAY;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
            bresp_q <= RESP_OKAY;
            case (axi_req.awaddr)
                ADDR_FREQ: if (&axi_req.wstrb) cfg.freq <= freq_wr;
                ADDR_OP: if (&axi_req.wstrb) cfg.op <= op_wr;
                default: bresp_q <= RESP_SLVERR;
            endcase
        end else if (axi_req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    // ##################################################
    // Read channel
    // ##################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            rresp_q <= RESP_OKAY;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
            rresp_q <= (axi_req.araddr == ADDR_FREQ || axi_req.araddr == ADDR_OP) ?
                       RESP_OKAY : RESP_SLVERR;
        end else if (axi_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (axi_req.araddr)
                ADDR_FREQ: rdata_q <= cfg.freq;
                ADDR_OP: rdata_q <= cfg.op;
                default: rdata_q <= '0;
            endcase
        end
    end

    always_comb begin
        axi_rsp.awready = wr_fire;
        axi_rsp.wready = wr_fire;
        axi_rsp.bvalid = bvalid_q;
        axi_rsp.bresp = bresp_q;
        axi_rsp.arready = rd_fire;
        axi_rsp.rvalid = rvalid_q;
        axi_rsp.rdata = rdata_q;
        axi_rsp.rresp = rresp_q;
    end

endmodule
